// ==== source/bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// global history length, also sets the global and chooser table index width.
`define BP_GHIST_BITS 8
`define BP_GLOBAL_ENTRIES (1 << `BP_GHIST_BITS)

// per-address history table, indexed by pc[7:2].
`define BP_LOCAL_IDX_BITS 6
`define BP_LOCAL_ENTRIES (1 << `BP_LOCAL_IDX_BITS)

// local history length, one pattern counter per history value.
`define BP_LHIST_BITS 6
`define BP_PATTERN_ENTRIES (1 << `BP_LHIST_BITS)

// direct-mapped target buffer, tag is the pc above the index.
`define BP_BTB_IDX_BITS 6
`define BP_BTB_ENTRIES (1 << `BP_BTB_IDX_BITS)
`define BP_BTB_TAG_BITS (30 - `BP_BTB_IDX_BITS)

// weakly not taken.
`define BP_CTR_INIT 2'b01

`endif

// ==== source/bp_pkg.sv ====
package bp_pkg;

    typedef enum logic [1:0] {
        OP_OTHER  = 2'd0,
        OP_BRANCH = 2'd1, // beq, bne.
        OP_JUMP   = 2'd2  // j, jal.
    } op_kind_e;

    typedef logic [1:0] ctr_t;

    // direction bits issued with a prediction and returned at resolve.
    typedef struct packed {
        logic global_dir;
        logic local_dir;
    } dir_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
    } fetch_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        dir_t        dir;
    } resolve_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        dir_t        dir;
    } update_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        dir_t        dir;
    } prediction_t;

    // 2-bit saturating counter, msb set means taken.
    function automatic ctr_t ctr_step(input ctr_t ctr, input logic up);
        ctr_t nxt;
        nxt = ctr;
        if (up && (ctr != 2'b11)) begin
            nxt = ctr + 2'd1;
        end else if (!up && (ctr != 2'b00)) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

endpackage

// ==== source/branch_decode.sv ====
`timescale 1ns/1ps

module branch_decode (
    input  logic [31:0]        instr,
    output bp_pkg::op_kind_e   kind
);
    import bp_pkg::*;

    logic [5:0] opcode;

    assign opcode = instr[31:26];

    // only the primary opcode matters, function fields are ignored.
    always_comb begin
        case (opcode)
            6'd4: begin
                kind = OP_BRANCH; // beq.
            end
            6'd5: begin
                kind = OP_BRANCH; // bne.
            end
            6'd2: begin
                kind = OP_JUMP;   // j.
            end
            6'd3: begin
                kind = OP_JUMP;   // jal.
            end
            default: begin
                kind = OP_OTHER;
            end
        endcase
    end

endmodule

// ==== source/global_predictor.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module global_predictor (
    input  logic             CLK,
    input  logic             RESET,
    input  logic [31:0]      pc,
    input  bp_pkg::update_t  update,
    output logic             taken
);
    import bp_pkg::*;

    logic [`BP_GHIST_BITS-1:0] ghist;
    ctr_t                      pht [0:`BP_GLOBAL_ENTRIES-1];
    logic [`BP_GHIST_BITS-1:0] rd_idx;
    logic [`BP_GHIST_BITS-1:0] wr_idx;

    // gshare hash of word address and global history.
    assign rd_idx = pc[`BP_GHIST_BITS+1:2] ^ ghist;
    assign wr_idx = update.pc[`BP_GHIST_BITS+1:2] ^ ghist;

    assign taken = pht[rd_idx][1];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ghist <= '0;
            for (int i = 0; i < `BP_GLOBAL_ENTRIES; i++) begin
                pht[i] <= `BP_CTR_INIT;
            end
        end else if (update.valid) begin
            // train with the history in place, then shift in the outcome.
            pht[wr_idx] <= ctr_step(pht[wr_idx], update.taken);
            ghist       <= {ghist[`BP_GHIST_BITS-2:0], update.taken};
        end
    end

endmodule

// ==== source/local_predictor.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module local_predictor (
    input  logic             CLK,
    input  logic             RESET,
    input  logic [31:0]      pc,
    input  bp_pkg::update_t  update,
    output logic             taken
);
    import bp_pkg::*;

    logic [`BP_LHIST_BITS-1:0]     lhist [0:`BP_LOCAL_ENTRIES-1];
    ctr_t                          pht   [0:`BP_PATTERN_ENTRIES-1];
    logic [`BP_LOCAL_IDX_BITS-1:0] rd_idx;
    logic [`BP_LOCAL_IDX_BITS-1:0] wr_idx;
    logic [`BP_LHIST_BITS-1:0]     rd_hist;
    logic [`BP_LHIST_BITS-1:0]     wr_hist;

    assign rd_idx  = pc[`BP_LOCAL_IDX_BITS+1:2];
    assign wr_idx  = update.pc[`BP_LOCAL_IDX_BITS+1:2];

    // first level, the branch's own recent outcomes.
    assign rd_hist = lhist[rd_idx];
    assign wr_hist = lhist[wr_idx];

    // second level, the pattern counter for that history.
    assign taken = pht[rd_hist][1];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `BP_LOCAL_ENTRIES; i++) begin
                lhist[i] <= '0;
            end
            for (int j = 0; j < `BP_PATTERN_ENTRIES; j++) begin
                pht[j] <= `BP_CTR_INIT;
            end
        end else if (update.valid) begin
            pht[wr_hist]  <= ctr_step(pht[wr_hist], update.taken);
            lhist[wr_idx] <= {wr_hist[`BP_LHIST_BITS-2:0], update.taken};
        end
    end

endmodule

// ==== source/tournament_chooser.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module tournament_chooser (
    input  logic             CLK,
    input  logic             RESET,
    input  logic [31:0]      pc,
    input  bp_pkg::update_t  update,
    input  logic             global_taken,
    input  logic             local_taken,
    output logic             taken
);
    import bp_pkg::*;

    ctr_t                      sel [0:`BP_GLOBAL_ENTRIES-1];
    logic [`BP_GHIST_BITS-1:0] rd_idx;
    logic [`BP_GHIST_BITS-1:0] wr_idx;
    logic                      disagree;
    logic                      global_won;

    assign rd_idx = pc[`BP_GHIST_BITS+1:2];
    assign wr_idx = update.pc[`BP_GHIST_BITS+1:2];

    // msb set selects the global guess.
    assign taken = sel[rd_idx][1] ? global_taken : local_taken;

    // when both agreed there is nothing to learn about who is better.
    assign disagree   = update.dir.global_dir ^ update.dir.local_dir;
    assign global_won = (update.dir.global_dir == update.taken);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `BP_GLOBAL_ENTRIES; i++) begin
                sel[i] <= `BP_CTR_INIT;
            end
        end else if (update.valid && disagree) begin
            sel[wr_idx] <= ctr_step(sel[wr_idx], global_won);
        end
    end

endmodule

// ==== source/branch_target_buffer.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module branch_target_buffer (
    input  logic             CLK,
    input  logic             RESET,
    input  logic [31:0]      pc,
    input  logic             is_branch,
    input  bp_pkg::update_t  update,
    output logic             hit,
    output logic [31:0]      target
);
    logic                        valid [0:`BP_BTB_ENTRIES-1];
    logic [`BP_BTB_TAG_BITS-1:0] tag   [0:`BP_BTB_ENTRIES-1];
    logic [31:0]                 dest  [0:`BP_BTB_ENTRIES-1];
    logic [`BP_BTB_IDX_BITS-1:0] rd_idx;
    logic [`BP_BTB_IDX_BITS-1:0] wr_idx;
    logic [`BP_BTB_TAG_BITS-1:0] rd_tag;

    assign rd_idx = pc[`BP_BTB_IDX_BITS+1:2];
    assign rd_tag = pc[31:`BP_BTB_IDX_BITS+2];
    assign wr_idx = update.pc[`BP_BTB_IDX_BITS+1:2];

    // a stale entry must not fire for a non-branch at the same pc.
    assign hit    = is_branch && valid[rd_idx] && (tag[rd_idx] == rd_tag);
    assign target = hit ? dest[rd_idx] : 32'd0;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (update.valid && update.taken) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // only taken branches carry a useful target.
    always_ff @(posedge CLK) begin
        if (update.valid && update.taken) begin
            tag[wr_idx]  <= update.pc[31:`BP_BTB_IDX_BITS+2];
            dest[wr_idx] <= update.target;
        end
    end

endmodule

// ==== source/hybrid_predictor.sv ====
`timescale 1ns/1ps

module hybrid_predictor (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  flush,
    input  bp_pkg::fetch_t        fetch,
    input  bp_pkg::resolve_t      resolve,
    output bp_pkg::prediction_t   pred
);
    import bp_pkg::*;

    op_kind_e    fetch_kind;
    op_kind_e    resolve_kind;
    update_t     update;
    logic        global_taken;
    logic        local_taken;
    logic        chosen;
    logic        btb_hit;
    logic [31:0] btb_target;

    branch_decode u_fetch_decode (
        .instr (fetch.instr),
        .kind  (fetch_kind)
    );

    branch_decode u_resolve_decode (
        .instr (resolve.instr),
        .kind  (resolve_kind)
    );

    // only control-flow instructions train the tables.
    assign update = '{
        valid:  resolve.valid && (resolve_kind != OP_OTHER),
        pc:     resolve.pc,
        taken:  resolve.taken,
        target: resolve.target,
        dir:    resolve.dir
    };

    global_predictor u_global_predictor (
        .CLK    (CLK),
        .RESET  (RESET),
        .pc     (fetch.pc),
        .update (update),
        .taken  (global_taken)
    );

    local_predictor u_local_predictor (
        .CLK    (CLK),
        .RESET  (RESET),
        .pc     (fetch.pc),
        .update (update),
        .taken  (local_taken)
    );

    tournament_chooser u_tournament_chooser (
        .CLK          (CLK),
        .RESET        (RESET),
        .pc           (fetch.pc),
        .update       (update),
        .global_taken (global_taken),
        .local_taken  (local_taken),
        .taken        (chosen)
    );

    // jumps count as branches for the lookup.
    branch_target_buffer u_branch_target_buffer (
        .CLK       (CLK),
        .RESET     (RESET),
        .pc        (fetch.pc),
        .is_branch (fetch_kind != OP_OTHER),
        .update    (update),
        .hit       (btb_hit),
        .target    (btb_target)
    );

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pred <= '0;
        end else if (flush || !fetch.valid) begin
            pred <= '0; // flush wins over a valid fetch.
        end else begin
            pred <= '{
                taken:  chosen && btb_hit,
                target: btb_target,
                dir:    '{global_dir: global_taken, local_dir: local_taken}
            };
        end
    end

endmodule

// ==== sim/tb_hybrid_predictor.sv ====
`timescale 1ns/1ps

module tb_hybrid_predictor;
    import bp_pkg::*;

    localparam logic [31:0] BEQ        = {6'd4, 26'd0};
    localparam logic [31:0] BEQ_PC     = 32'h0000_1040;
    localparam logic [31:0] BEQ_TARGET = 32'h0000_2000;
    localparam logic [31:0] ALT_PC     = 32'h0000_1080;
    localparam logic [31:0] NOISE_PC   = 32'h0000_1100;

    logic        CLK;
    logic        RESET;
    logic        flush;
    fetch_t      fetch;
    resolve_t    resolve;
    prediction_t pred;
    prediction_t exp_pred; // what pred must show after the next edge.

    // reference copies of the four tables.
    logic [1:0]  m_gpht  [256];
    logic [7:0]  m_ghist;
    logic [5:0]  m_lhist [64];
    logic [1:0]  m_lpht  [64];
    logic [1:0]  m_sel   [256];
    logic        m_bv    [64];
    logic [23:0] m_btag  [64];
    logic [31:0] m_bdest [64];
    int          mix_ops [8] = '{0, 2, 3, 4, 5, 8, 35, 43};
    int          errors;
    int          checks;
    int          test_errors;
    string       test_name;

    hybrid_predictor u_hybrid_predictor (
        .CLK     (CLK),
        .RESET   (RESET),
        .flush   (flush),
        .fetch   (fetch),
        .resolve (resolve),
        .pred    (pred)
    );

    always #50 CLK = ~CLK;

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end else begin
            return (c == 2'd0) ? c : c - 2'd1;
        end
    endfunction

    function automatic logic is_control(input logic [31:0] instr);
        return instr[31:26] inside {6'd2, 6'd3, 6'd4, 6'd5};
    endfunction

    function automatic logic [31:0] make_instr(input int op);
        logic [31:0] r;
        r = $urandom;
        return {op[5:0], r[25:0]};
    endfunction

    // a small pool of pcs keeps index and tag collisions frequent.
    function automatic logic [31:0] pool_pc();
        return 32'h1000 + 32'h400 * $urandom_range(0, 3) + 32'h4 * $urandom_range(0, 7);
    endfunction

    function automatic resolve_t resolve_of(input logic [31:0] instr, input logic [31:0] pc,
                                            input logic taken, input logic [31:0] target,
                                            input dir_t dir);
        return '{valid: 1'b1, instr: instr, pc: pc, taken: taken, target: target, dir: dir};
    endfunction

    task automatic check_dir(input dir_t expected, input dir_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Fail at %0t ns: %s pred.dir expected %b got %b",
                     $time, test_name, expected, actual);
        end
    endtask

    task automatic check_prediction(input prediction_t expected, input prediction_t actual);
        checks++;
        if (actual.taken !== expected.taken || actual.target !== expected.target) begin
            errors++;
            test_errors++;
            $display("Fail at %0t ns: %s pred.taken/target expected %b/%h got %b/%h", $time,
                     test_name, expected.taken, expected.target, actual.taken, actual.target);
        end
        check_dir(expected.dir, actual.dir);
    endtask

    // checks the last result, drives one cycle, then reads and trains the model.
    task automatic step(input fetch_t f, input resolve_t r, input logic fl);
        logic [7:0] gi;
        logic [5:0] li;
        logic [5:0] h;
        logic       g;
        logic       l;
        logic       hit;
        check_prediction(exp_pred, pred);
        fetch   = f;
        resolve = r;
        flush   = fl;
        g   = m_gpht[f.pc[9:2] ^ m_ghist][1];
        l   = m_lpht[m_lhist[f.pc[7:2]]][1];
        li  = f.pc[7:2];
        hit = is_control(f.instr) && m_bv[li] && (m_btag[li] == f.pc[31:8]);
        if (fl || !f.valid) begin
            exp_pred = '0;
        end else begin
            exp_pred.taken  = (m_sel[f.pc[9:2]][1] ? g : l) && hit;
            exp_pred.target = hit ? m_bdest[li] : 32'd0;
            exp_pred.dir    = {g, l};
        end
        if (r.valid && is_control(r.instr)) begin
            gi = r.pc[9:2] ^ m_ghist;
            li = r.pc[7:2];
            h  = m_lhist[li];
            m_gpht[gi]  = saturate(m_gpht[gi], r.taken);
            m_ghist     = {m_ghist[6:0], r.taken};
            m_lpht[h]   = saturate(m_lpht[h], r.taken);
            m_lhist[li] = {h[4:0], r.taken};
            if (r.dir.global_dir != r.dir.local_dir) begin
                m_sel[r.pc[9:2]] = saturate(m_sel[r.pc[9:2]], r.dir.global_dir == r.taken);
            end
            if (r.taken) begin
                m_bv[li]    = 1'b1;
                m_btag[li]  = r.pc[31:8];
                m_bdest[li] = r.target;
            end
        end
        @(negedge CLK);
    endtask

    task automatic finish_test(input string note);
        step('0, '0, 1'b0); // last prediction of the test is checked here.
        $display("%s finished with %0d errors %s", test_name, test_errors, note);
        test_errors = 0;
    endtask

    initial begin
        fetch_t   f;
        resolve_t r;
        dir_t     d;
        int       n;
        int       first_taken;
        void'($urandom(32'ha596));
        CLK      = 1'b0;
        RESET    = 1'b0;
        flush    = 1'b0;
        fetch    = '0;
        resolve  = '0;
        exp_pred = '0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        m_ghist     = '0;
        for (int i = 0; i < 256; i++) begin
            m_gpht[i] = 2'b01;
            m_sel[i]  = 2'b01;
        end
        for (int i = 0; i < 64; i++) begin
            m_lhist[i] = '0;
            m_lpht[i]  = 2'b01;
            m_bv[i]    = 1'b0;
        end
        repeat (2) @(negedge CLK);
        RESET = 1'b1;
        n = 0;
        while (pred !== '0 && n < 10) begin
            @(negedge CLK);
            n++;
        end
        if (pred !== '0) begin
            $display("Timeout: the prediction register never cleared after reset");
            $display("Regression failed");
            $finish;
        end

        test_name = "reset_idle";
        for (int i = 0; i < 20; i++) begin
            f = '{valid: 1'b1, instr: make_instr($urandom_range(6, 63)), pc: pool_pc()};
            r = resolve_of(make_instr($urandom_range(6, 63)), pool_pc(), 1'b1, $urandom, 2'b11);
            step(f, r, 1'b0);
            check_prediction('0, pred); // initial counters say not taken.
        end
        finish_test("");

        test_name   = "beq_training";
        first_taken = -1;
        for (int k = 0; k < 12; k++) begin
            step('{valid: 1'b1, instr: BEQ, pc: BEQ_PC}, '0, 1'b0);
            d = exp_pred.dir;
            if (exp_pred.taken && first_taken < 0) begin
                first_taken = k;
            end
            step('0, resolve_of(BEQ, BEQ_PC, 1'b1, BEQ_TARGET, d), 1'b0);
        end
        if (first_taken < 0) begin
            errors++;
            test_errors++;
            $display("The trained beq was never predicted taken by the model");
        end
        finish_test($sformatf("(taken after %0d resolutions)", first_taken));

        test_name = "alternating";
        for (int k = 0; k < 32; k++) begin
            // a random branch elsewhere muddies the global history.
            r = resolve_of(BEQ, NOISE_PC, 1'($urandom_range(0, 1)), 32'h3000,
                           2'($urandom_range(0, 3)));
            step('{valid: 1'b1, instr: BEQ, pc: ALT_PC}, r, 1'b0);
            d = exp_pred.dir;
            step('0, resolve_of(BEQ, ALT_PC, k[0], 32'h4000, d), 1'b0);
        end
        if (m_sel[ALT_PC[9:2]][1]) begin
            errors++;
            test_errors++;
            $display("The chooser did not settle on the local guess for the alternating branch");
        end
        finish_test($sformatf("(chooser counter %0d)", m_sel[ALT_PC[9:2]]));

        test_name = "flush";
        step('{valid: 1'b1, instr: BEQ, pc: BEQ_PC}, '0, 1'b1);
        check_prediction('0, pred);
        for (int k = 0; k < 10; k++) begin
            step('{valid: 1'b1, instr: BEQ, pc: BEQ_PC}, '0, 1'b0);
        end
        finish_test("");

        test_name = "random_mix";
        for (int k = 0; k < 400; k++) begin
            f = '{valid: 1'b1, instr: make_instr(mix_ops[$urandom_range(0, 7)]), pc: pool_pc()};
            f.valid = ($urandom_range(0, 3) != 0);
            r = resolve_of(make_instr(mix_ops[$urandom_range(0, 7)]), pool_pc(),
                           1'($urandom_range(0, 1)), $urandom & 32'hffff_fffc,
                           2'($urandom_range(0, 3)));
            r.valid = ($urandom_range(0, 3) != 0);
            step(f, r, ($urandom_range(0, 31) == 0));
        end
        finish_test("");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/bp_pkg.sv
source/branch_decode.sv
source/global_predictor.sv
source/local_predictor.sv
source/tournament_chooser.sv
source/branch_target_buffer.sv
source/hybrid_predictor.sv
sim/tb_hybrid_predictor.sv

// ==== Bender.yml ====
package:
  name: hybrid_predictor

sources:
  - include_dirs:
      - source
    files:
      - source/bp_pkg.sv
      - source/branch_decode.sv
      - source/global_predictor.sv
      - source/local_predictor.sv
      - source/tournament_chooser.sv
      - source/branch_target_buffer.sv
      - source/hybrid_predictor.sv
  - target: test
    files:
      - sim/tb_hybrid_predictor.sv
